// ==== source/reflet_pkg.sv ====
// ============================
// Reflet peripheral package
// register map of the peripheral window,
// word widths and the shared enums
// ============================

package reflet_pkg;

    // register index inside one peripheral and offset inside the window
    localparam int reg_idx_width = 3;
    localparam int offset_width  = 4;
    localparam int total_size    = 16;

    // offset and size of each peripheral
    localparam int imux_off   = 0;
    localparam int imux_size  = 4;
    localparam int gpio_off   = imux_off + imux_size;
    localparam int gpio_size  = 5;
    localparam int timer_off  = gpio_off + gpio_size;
    localparam int timer_size = 3;
    localparam int uart_off   = timer_off + timer_size;
    localparam int uart_size  = 4;

    typedef enum logic [1:0] {
        periph_imux,
        periph_gpio,
        periph_timer,
        periph_uart
    } periph_e;

    typedef enum logic [1:0] {
        src_none,
        src_gpio,
        src_timer,
        src_uart
    } irq_source_e;

    typedef enum logic {
        tmr_stopped,
        tmr_running
    } timer_state_e;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } uart_state_e;

endpackage

// ==== source/reflet_periph_bus_if.sv ====
// ============================
// Reflet peripheral register bus
// one register access path from the
// decoder to a single peripheral
// ============================

`timescale 1ns/1ps

interface reflet_periph_bus_if;

    logic                                 sel;
    logic [reflet_pkg::reg_idx_width-1:0] reg_idx;
    logic [7:0]                           wdata;
    logic                                 write_en;
    // zero when sel is low
    logic [7:0]                           rdata;

    modport decoder (
        output sel,
        output reg_idx,
        output wdata,
        output write_en,
        input  rdata
    );

    modport periph (
        input  sel,
        input  reg_idx,
        input  wdata,
        input  write_en,
        output rdata
    );

endinterface

// ==== source/reflet_periph_decoder.sv ====
// ============================
// Reflet peripheral decoder
// checks the address window, selects one
// peripheral and gathers the read data
// ============================

`timescale 1ns/1ps

module reflet_periph_decoder #(
    parameter int                        base_addr_size = 16,
    parameter logic [base_addr_size-1:0] base_addr      = 16'hFF00
) (
    input  logic                      enable,
    input  logic [base_addr_size-1:0] addr,
    input  logic [7:0]                data_in,
    input  logic                      write_en,
    output logic [7:0]                data_out,
    reflet_periph_bus_if.decoder      imux_bus,
    reflet_periph_bus_if.decoder      gpio_bus,
    reflet_periph_bus_if.decoder      timer_bus,
    reflet_periph_bus_if.decoder      uart_bus
);

    logic [base_addr_size-1:0]            rel_addr;
    logic                                 in_window;
    logic [reflet_pkg::offset_width-1:0]  offset;
    logic [reflet_pkg::offset_width-1:0]  base;
    logic [reflet_pkg::offset_width-1:0]  local_off;
    reflet_pkg::periph_e                  target;

    // compare on the difference so a window near the top does not wrap
    assign rel_addr  = addr - base_addr;
    assign in_window = enable && (addr >= base_addr) && (rel_addr < reflet_pkg::total_size);
    assign offset    = rel_addr[reflet_pkg::offset_width-1:0];

    always_comb
    begin
        target = reflet_pkg::periph_imux;
        base   = '0;
        if (offset < reflet_pkg::imux_off + reflet_pkg::imux_size)
        begin
            target = reflet_pkg::periph_imux;
            base   = reflet_pkg::offset_width'(reflet_pkg::imux_off);
        end
        else if (offset < reflet_pkg::gpio_off + reflet_pkg::gpio_size)
        begin
            target = reflet_pkg::periph_gpio;
            base   = reflet_pkg::offset_width'(reflet_pkg::gpio_off);
        end
        else if (offset < reflet_pkg::timer_off + reflet_pkg::timer_size)
        begin
            target = reflet_pkg::periph_timer;
            base   = reflet_pkg::offset_width'(reflet_pkg::timer_off);
        end
        else if (offset < reflet_pkg::uart_off + reflet_pkg::uart_size)
        begin
            target = reflet_pkg::periph_uart;
            base   = reflet_pkg::offset_width'(reflet_pkg::uart_off);
        end
    end

    // no peripheral is larger than 8 registers
    assign local_off = offset - base;

    assign imux_bus.sel  = in_window && (target == reflet_pkg::periph_imux);
    assign gpio_bus.sel  = in_window && (target == reflet_pkg::periph_gpio);
    assign timer_bus.sel = in_window && (target == reflet_pkg::periph_timer);
    assign uart_bus.sel  = in_window && (target == reflet_pkg::periph_uart);

    assign imux_bus.reg_idx  = local_off[reflet_pkg::reg_idx_width-1:0];
    assign gpio_bus.reg_idx  = local_off[reflet_pkg::reg_idx_width-1:0];
    assign timer_bus.reg_idx = local_off[reflet_pkg::reg_idx_width-1:0];
    assign uart_bus.reg_idx  = local_off[reflet_pkg::reg_idx_width-1:0];

    assign imux_bus.wdata  = data_in;
    assign gpio_bus.wdata  = data_in;
    assign timer_bus.wdata = data_in;
    assign uart_bus.wdata  = data_in;

    assign imux_bus.write_en  = write_en;
    assign gpio_bus.write_en  = write_en;
    assign timer_bus.write_en = write_en;
    assign uart_bus.write_en  = write_en;

    // unselected peripherals return zero
    assign data_out = imux_bus.rdata | gpio_bus.rdata | timer_bus.rdata | uart_bus.rdata;

endmodule

// ==== source/reflet_interrupt_mux.sv ====
// ============================
// Reflet interrupt router
// four route registers, each mapping one
// interrupt source to a CPU interrupt line
// ============================

`timescale 1ns/1ps

module reflet_interrupt_mux (
    input  logic                clk,
    input  logic                arst_n,
    reflet_periph_bus_if.periph bus,
    input  logic                gpio_irq,
    input  logic                timer_irq,
    input  logic                uart_irq,
    output logic [3:0]          interrupt_request
);

    reflet_pkg::irq_source_e route [4];
    logic                    idx_valid;
    logic [1:0]              line;

    assign idx_valid = bus.reg_idx < reflet_pkg::imux_size;
    assign line      = bus.reg_idx[1:0];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 4; i++)
            begin
                route[i] <= reflet_pkg::src_none;
            end
        end
        else if (bus.sel && bus.write_en && idx_valid)
        begin
            route[line] <= reflet_pkg::irq_source_e'(bus.wdata[1:0]);
        end
    end

    always_comb
    begin
        bus.rdata = 8'h00;
        if (bus.sel && idx_valid)
        begin
            bus.rdata = {6'b0, route[line]};
        end
    end

    // each line follows the pulse of its routed source
    always_comb
    begin
        for (int n = 0; n < 4; n++)
        begin
            case (route[n])
                reflet_pkg::src_gpio:  interrupt_request[n] = gpio_irq;
                reflet_pkg::src_timer: interrupt_request[n] = timer_irq;
                reflet_pkg::src_uart:  interrupt_request[n] = uart_irq;
                default:               interrupt_request[n] = 1'b0;
            endcase
        end
    end

endmodule

// ==== source/reflet_gpio.sv ====
// ============================
// Reflet GPIO
// 16 sampled inputs, 16 outputs and an
// interrupt on any input change
// ============================

`timescale 1ns/1ps

module reflet_gpio (
    input  logic                clk,
    input  logic                arst_n,
    reflet_periph_bus_if.periph bus,
    input  logic [15:0]         gpi,
    output logic [15:0]         gpo,
    output logic                irq
);

    localparam logic [2:0] reg_gpi_lo = 3'd0;
    localparam logic [2:0] reg_gpi_hi = 3'd1;
    localparam logic [2:0] reg_gpo_lo = 3'd2;
    localparam logic [2:0] reg_gpo_hi = 3'd3;
    localparam logic [2:0] reg_int_en = 3'd4;

    logic [15:0] gpi_q;
    logic [15:0] gpi_prev;
    logic        int_en;
    logic        wr;

    assign wr = bus.sel && bus.write_en;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            gpi_q    <= '0;
            gpi_prev <= '0;
            gpo      <= '0;
            int_en   <= 1'b0;
            irq      <= 1'b0;
        end
        else
        begin
            gpi_q    <= gpi;
            gpi_prev <= gpi_q;
            // one cycle pulse, the previous sample catches up next edge
            irq      <= int_en && (gpi_q != gpi_prev);
            if (wr && bus.reg_idx == reg_gpo_lo)
            begin
                gpo[7:0] <= bus.wdata;
            end
            if (wr && bus.reg_idx == reg_gpo_hi)
            begin
                gpo[15:8] <= bus.wdata;
            end
            if (wr && bus.reg_idx == reg_int_en)
            begin
                int_en <= bus.wdata[0];
            end
        end
    end

    always_comb
    begin
        bus.rdata = 8'h00;
        if (bus.sel)
        begin
            case (bus.reg_idx)
                reg_gpi_lo: bus.rdata = gpi_q[7:0];
                reg_gpi_hi: bus.rdata = gpi_q[15:8];
                reg_gpo_lo: bus.rdata = gpo[7:0];
                reg_gpo_hi: bus.rdata = gpo[15:8];
                reg_int_en: bus.rdata = {7'b0, int_en};
                default:    bus.rdata = 8'h00;
            endcase
        end
    end

endmodule

// ==== source/reflet_timer.sv ====
// ============================
// Reflet timer
// reloading 16-bit down counter with a
// run bit and a period interrupt
// ============================

`timescale 1ns/1ps

module reflet_timer (
    input  logic                clk,
    input  logic                arst_n,
    reflet_periph_bus_if.periph bus,
    output logic                irq
);

    localparam logic [2:0] reg_reload_lo = 3'd0;
    localparam logic [2:0] reg_reload_hi = 3'd1;
    localparam logic [2:0] reg_ctrl      = 3'd2;

    logic [15:0]              reload;
    logic [15:0]              count;
    reflet_pkg::timer_state_e state;
    logic                     wr;

    assign wr = bus.sel && bus.write_en;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            reload <= '0;
            count  <= '0;
            state  <= reflet_pkg::tmr_stopped;
            irq    <= 1'b0;
        end
        else
        begin
            irq <= 1'b0;
            if (wr && bus.reg_idx == reg_reload_lo)
            begin
                reload[7:0] <= bus.wdata;
            end
            if (wr && bus.reg_idx == reg_reload_hi)
            begin
                reload[15:8] <= bus.wdata;
            end
            if (wr && bus.reg_idx == reg_ctrl)
            begin
                // setting run restarts from reload
                if (bus.wdata[0])
                begin
                    state <= reflet_pkg::tmr_running;
                    count <= reload;
                end
                else
                begin
                    state <= reflet_pkg::tmr_stopped;
                end
            end
            else if (state == reflet_pkg::tmr_running)
            begin
                if (count == 16'd0)
                begin
                    count <= reload;
                    irq   <= 1'b1;
                end
                else
                begin
                    count <= count - 16'd1;
                end
            end
        end
    end

    always_comb
    begin
        bus.rdata = 8'h00;
        if (bus.sel)
        begin
            case (bus.reg_idx)
                reg_reload_lo: bus.rdata = reload[7:0];
                reg_reload_hi: bus.rdata = reload[15:8];
                reg_ctrl:      bus.rdata = {7'b0, state == reflet_pkg::tmr_running};
                default:       bus.rdata = 8'h00;
            endcase
        end
    end

endmodule

// ==== source/reflet_uart_tx.sv ====
// ============================
// Reflet UART transmitter
// 8N1 serial output with a busy flag
// and a frame done interrupt
// ============================

`timescale 1ns/1ps

module reflet_uart_tx #(
    parameter int clk_freq  = 1000000,
    parameter int baud_rate = 62500
) (
    input  logic                clk,
    input  logic                arst_n,
    reflet_periph_bus_if.periph bus,
    output logic                tx,
    output logic                irq
);

    localparam int bit_period = clk_freq / baud_rate;
    localparam int cnt_width  = (bit_period > 1) ? $clog2(bit_period) : 1;
    localparam logic [cnt_width-1:0] last_tick = cnt_width'(bit_period - 1);

    localparam logic [2:0] reg_data   = 3'd0;
    localparam logic [2:0] reg_status = 3'd1;

    reflet_pkg::uart_state_e state;
    logic [cnt_width-1:0]    baud_cnt;
    logic [2:0]              bit_cnt;
    logic [7:0]              shift;
    logic                    busy;
    logic                    start;
    logic                    bit_end;

    assign busy    = state != reflet_pkg::tx_idle;
    // writes while busy are dropped
    assign start   = bus.sel && bus.write_en && bus.reg_idx == reg_data && !busy;
    assign bit_end = baud_cnt == last_tick;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= reflet_pkg::tx_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            irq      <= 1'b0;
        end
        else
        begin
            irq <= 1'b0;
            if (busy)
            begin
                baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            end
            case (state)
                reflet_pkg::tx_idle:
                    if (start)
                    begin
                        state    <= reflet_pkg::tx_start;
                        baud_cnt <= '0;
                    end
                reflet_pkg::tx_start:
                    if (bit_end)
                    begin
                        state   <= reflet_pkg::tx_data;
                        bit_cnt <= '0;
                    end
                reflet_pkg::tx_data:
                    if (bit_end)
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                        begin
                            state <= reflet_pkg::tx_stop;
                        end
                    end
                default:
                    if (bit_end)
                    begin
                        state <= reflet_pkg::tx_idle;
                        irq   <= 1'b1;
                    end
            endcase
        end
    end

    // data shifts out lsb first
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            shift <= bus.wdata;
        end
        else if (state == reflet_pkg::tx_data && bit_end)
        begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    always_comb
    begin
        case (state)
            reflet_pkg::tx_start: tx = 1'b0;
            reflet_pkg::tx_data:  tx = shift[0];
            default:              tx = 1'b1;
        endcase
    end

    // data and reserved registers read zero
    assign bus.rdata = (bus.sel && bus.reg_idx == reg_status) ? {7'b0, busy} : 8'h00;

endmodule

// ==== source/reflet_peripheral.sv ====
// ============================
// Reflet peripheral block
// memory mapped interrupt router, GPIO,
// timer and UART behind one byte window
// ============================

`timescale 1ns/1ps

module reflet_peripheral #(
    parameter int                        base_addr_size = 16,
    parameter logic [base_addr_size-1:0] base_addr      = 16'hFF00,
    parameter int                        clk_freq       = 1000000,
    parameter int                        baud_rate      = 62500
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      enable,
    input  logic [base_addr_size-1:0] addr,
    input  logic [7:0]                data_in,
    input  logic                      write_en,
    output logic [7:0]                data_out,
    output logic [3:0]                interrupt_request,
    input  logic [15:0]               gpi,
    output logic [15:0]               gpo,
    output logic                      tx
);

    logic gpio_irq;
    logic timer_irq;
    logic uart_irq;

    reflet_periph_bus_if imux_bus ();
    reflet_periph_bus_if gpio_bus ();
    reflet_periph_bus_if timer_bus ();
    reflet_periph_bus_if uart_bus ();

    reflet_periph_decoder #(
        .base_addr_size(base_addr_size),
        .base_addr(base_addr)
    ) decoder (
        .enable(enable),
        .addr(addr),
        .data_in(data_in),
        .write_en(write_en),
        .data_out(data_out),
        .imux_bus(imux_bus.decoder),
        .gpio_bus(gpio_bus.decoder),
        .timer_bus(timer_bus.decoder),
        .uart_bus(uart_bus.decoder)
    );

    reflet_interrupt_mux interrupt_mux (
        .clk(clk),
        .arst_n(arst_n),
        .bus(imux_bus.periph),
        .gpio_irq(gpio_irq),
        .timer_irq(timer_irq),
        .uart_irq(uart_irq),
        .interrupt_request(interrupt_request)
    );

    reflet_gpio gpio (
        .clk(clk),
        .arst_n(arst_n),
        .bus(gpio_bus.periph),
        .gpi(gpi),
        .gpo(gpo),
        .irq(gpio_irq)
    );

    reflet_timer timer (
        .clk(clk),
        .arst_n(arst_n),
        .bus(timer_bus.periph),
        .irq(timer_irq)
    );

    // bit period is clk_freq / baud_rate cycles
    reflet_uart_tx #(
        .clk_freq(clk_freq),
        .baud_rate(baud_rate)
    ) uart (
        .clk(clk),
        .arst_n(arst_n),
        .bus(uart_bus.periph),
        .tx(tx),
        .irq(uart_irq)
    );

endmodule

// ==== test/reflet_periph_checker.sv ====
// ============================
// Reflet peripheral checker
// register map model, interrupt line and
// UART frame reference, output compares
// ============================

`timescale 1ns/1ps

module reflet_periph_checker #(
    parameter logic [15:0] base_addr = 16'hFF00
) (
    input logic        clk,
    input logic        arst_n,
    input logic        enable,
    input logic [15:0] addr,
    input logic [7:0]  data_in,
    input logic        write_en,
    input logic [7:0]  data_out,
    input logic [3:0]  interrupt_request,
    input logic [15:0] gpi,
    input logic [15:0] gpo,
    input logic        tx
);

    // 1 MHz clock at 62500 baud
    localparam int bit_cycles = 16;

    logic [7:0]              shadow [16];
    logic [15:0]             gpi_seen;
    logic                    busy_ref;
    int                      busy_cnt;
    logic [7:0]              frame_byte;
    logic [15:0]             rel;
    logic                    in_win;
    logic [3:0]              exp_irq;
    reflet_pkg::irq_source_e active_src = reflet_pkg::src_none;
    int                      pulse_count [4] = '{0, 0, 0, 0};
    longint                  last_pulse [4];
    longint                  cycle = 0;
    int                      error_count = 0;
    int                      test_start_errors = 0;
    int                      tests_run = 0;
    int                      tests_failed = 0;

    assign rel    = addr - base_addr;
    assign in_win = enable && (addr >= base_addr) && (rel < 16);

    function automatic logic [7:0] expected_read(input logic en, input logic [15:0] a);
        logic [15:0] off;
        off = a - base_addr;
        if (!en || a < base_addr || off >= 16)
            return 8'h00;
        case (off[3:0])
            4'd4:                return gpi_seen[7:0];
            4'd5:                return gpi_seen[15:8];
            4'd13:               return {7'b0, busy_ref};
            4'd12, 4'd14, 4'd15: return 8'h00;
            default:             return shadow[off[3:0]];
        endcase
    endfunction

    function automatic logic expected_line(input reflet_pkg::irq_source_e route,
                                           input reflet_pkg::irq_source_e pulsing);
        return (pulsing != reflet_pkg::src_none) && (route == pulsing);
    endfunction

    // start bit, data lsb first, stop bit
    function automatic logic frame_bit(input logic [7:0] data, input int idx);
        if (idx == 0)
            return 1'b0;
        if (idx == 9)
            return 1'b1;
        return data[idx-1];
    endfunction

    function automatic int timer_gap();
        return int'({shadow[10], shadow[9]}) + 1;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("Error: %s", what);
        error_count++;
    endtask

    task automatic clear_pulses();
        for (int n = 0; n < 4; n++)
        begin
            pulse_count[n] = 0;
        end
    endtask

    task automatic set_active(input reflet_pkg::irq_source_e src);
        active_src = src;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count == test_start_errors)
        begin
            $display("%s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    task automatic final_report();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    endtask

    // register shadow and UART busy model
    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 16; i++)
            begin
                shadow[i] <= 8'h00;
            end
            gpi_seen   <= '0;
            busy_ref   <= 1'b0;
            busy_cnt   <= 0;
            frame_byte <= 8'h00;
        end
        else
        begin
            gpi_seen <= gpi;
            if (in_win && write_en)
            begin
                case (rel[3:0])
                    4'd0, 4'd1, 4'd2, 4'd3:  shadow[rel[3:0]] <= {6'b0, data_in[1:0]};
                    4'd6, 4'd7, 4'd9, 4'd10: shadow[rel[3:0]] <= data_in;
                    4'd8, 4'd11:             shadow[rel[3:0]] <= {7'b0, data_in[0]};
                    default:                 ;
                endcase
            end
            if (in_win && write_en && rel[3:0] == 4'd12 && !busy_ref)
            begin
                busy_ref   <= 1'b1;
                busy_cnt   <= 0;
                frame_byte <= data_in;
            end
            else if (busy_ref)
            begin
                if (busy_cnt == 10 * bit_cycles - 1)
                    busy_ref <= 1'b0;
                else
                    busy_cnt <= busy_cnt + 1;
            end
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (arst_n)
        begin
            cycle++;
            check_value("data_out", data_out, expected_read(enable, addr));
            check_value("gpo", gpo, {shadow[7], shadow[6]});
            for (int n = 0; n < 4; n++)
            begin
                exp_irq[n] = expected_line(reflet_pkg::irq_source_e'(shadow[n][1:0]),
                                           active_src);
            end
            if (interrupt_request != 4'b0000)
            begin
                check_value("interrupt_request", interrupt_request, exp_irq);
            end
            for (int n = 0; n < 4; n++)
            begin
                if (interrupt_request[n])
                begin
                    if (active_src == reflet_pkg::src_timer && pulse_count[n] > 0)
                    begin
                        check_value("timer pulse gap", 16'(cycle - last_pulse[n]),
                                    16'(timer_gap()));
                    end
                    pulse_count[n]++;
                    last_pulse[n] = cycle;
                end
            end
            if (!busy_ref)
                check_value("tx", tx, 1'b1);
            else if (busy_cnt % bit_cycles == bit_cycles / 2)
                check_value("tx", tx, frame_bit(frame_byte, busy_cnt / bit_cycles));
        end
    end

endmodule

// ==== test/tb_reflet_peripheral.sv ====
// ============================
// Reflet peripheral testbench
// drives the processor bus and pins through
// window, GPIO, timer, UART and routing tests
// ============================

`timescale 1ns/1ps

module tb_reflet_peripheral;

    localparam logic [15:0] base_addr = 16'hFF00;

    logic        clk;
    logic        arst_n;
    logic        enable;
    logic [15:0] addr;
    logic [7:0]  data_in;
    logic        write_en;
    logic [7:0]  data_out;
    logic [3:0]  interrupt_request;
    logic [15:0] gpi;
    logic [15:0] gpo;
    logic        tx;
    int unsigned seed;
    int unsigned rnd;
    int          reload;

    reflet_peripheral #(
        .base_addr_size(16),
        .base_addr(base_addr),
        .clk_freq(1000000),
        .baud_rate(62500)
    ) reflet_peripheral_i (
        .clk(clk),
        .arst_n(arst_n),
        .enable(enable),
        .addr(addr),
        .data_in(data_in),
        .write_en(write_en),
        .data_out(data_out),
        .interrupt_request(interrupt_request),
        .gpi(gpi),
        .gpo(gpo),
        .tx(tx)
    );

    reflet_periph_checker #(
        .base_addr(base_addr)
    ) periph_check (
        .clk(clk),
        .arst_n(arst_n),
        .enable(enable),
        .addr(addr),
        .data_in(data_in),
        .write_en(write_en),
        .data_out(data_out),
        .interrupt_request(interrupt_request),
        .gpi(gpi),
        .gpo(gpo),
        .tx(tx)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [15:0] reg_addr(input int off);
        return base_addr + 16'(off);
    endfunction

    // one bus cycle, then the bus goes idle
    task automatic bus_access(input logic en, input logic we, input logic [15:0] a,
                              input logic [7:0] d);
        @(posedge clk);
        enable   <= en;
        write_en <= we;
        addr     <= a;
        data_in  <= d;
        @(posedge clk);
        enable   <= 1'b0;
        write_en <= 1'b0;
    endtask

    task automatic bus_write(input int off, input logic [7:0] d);
        bus_access(1'b1, 1'b1, reg_addr(off), d);
    endtask

    task automatic bus_read(input int off);
        bus_access(1'b1, 1'b0, reg_addr(off), 8'h00);
    endtask

    task automatic wait_pulses(input int line, input int target, input int limit,
                               input string what);
        int cycles;
        cycles = 0;
        while (periph_check.pulse_count[line] < target && cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        if (periph_check.pulse_count[line] < target)
        begin
            periph_check.note_failure({"timed out waiting for ", what});
        end
    endtask

    initial
    begin
        seed     = 32'h9e54;
        rnd      = $urandom(seed);
        arst_n   = 1'b0;
        enable   = 1'b0;
        write_en = 1'b0;
        addr     = '0;
        data_in  = '0;
        gpi      = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // read-back, window edges and enable low
        bus_write(6, 8'($urandom));
        bus_write(7, 8'($urandom));
        bus_write(9, 8'($urandom));
        bus_write(10, 8'($urandom));
        for (int i = 0; i < 16; i++)
        begin
            bus_read(i);
        end
        bus_access(1'b1, 1'b1, base_addr + 16'h10, 8'($urandom));
        bus_access(1'b1, 1'b1, base_addr - 16'h1, 8'($urandom));
        bus_access(1'b0, 1'b1, reg_addr(6), 8'($urandom));
        bus_access(1'b0, 1'b0, reg_addr(9), 8'h00);
        bus_access(1'b1, 1'b0, base_addr + 16'h10, 8'h00);
        for (int i = 0; i < 16; i++)
        begin
            bus_read(i);
        end
        periph_check.end_test("register read-back and window");

        @(posedge clk);
        gpi <= 16'($urandom);
        repeat (3) @(posedge clk);
        bus_read(4);
        bus_read(5);
        periph_check.set_active(reflet_pkg::src_gpio);
        bus_write(8, 8'h01);
        bus_write(1, 8'(reflet_pkg::src_gpio));
        periph_check.clear_pulses();
        @(posedge clk);
        gpi <= gpi ^ (16'($urandom) | 16'h0001);
        wait_pulses(1, 1, 20, "gpio interrupt");
        repeat (10) @(posedge clk);
        periph_check.check_value("interrupt_request[1] pulses", 16'(periph_check.pulse_count[1]),
                                 16'd1);
        bus_write(8, 8'h00);
        @(posedge clk);
        gpi <= gpi ^ (16'($urandom) | 16'h0001);
        repeat (10) @(posedge clk);
        bus_read(4);
        bus_read(5);
        periph_check.check_value("interrupt_request[1] pulses", 16'(periph_check.pulse_count[1]),
                                 16'd1);
        periph_check.end_test("gpio");

        // pulse gaps are compared in the checker
        reload = 3 + int'($urandom % 38);
        periph_check.set_active(reflet_pkg::src_timer);
        bus_write(0, 8'(reflet_pkg::src_timer));
        bus_write(9, 8'(reload));
        bus_write(10, 8'h00);
        periph_check.clear_pulses();
        bus_write(11, 8'h01);
        wait_pulses(0, 4, 300, "timer interrupts");
        bus_write(11, 8'h00);
        periph_check.clear_pulses();
        repeat (100) @(posedge clk);
        periph_check.check_value("interrupt_request[0] pulses", 16'(periph_check.pulse_count[0]),
                                 16'd0);
        periph_check.end_test("timer period");

        periph_check.set_active(reflet_pkg::src_uart);
        bus_write(2, 8'(reflet_pkg::src_uart));
        periph_check.clear_pulses();
        bus_write(12, 8'($urandom));
        bus_read(13);
        // dropped while the frame runs
        bus_write(12, 8'($urandom));
        bus_read(13);
        wait_pulses(2, 1, 400, "uart done interrupt");
        bus_read(13);
        repeat (20) @(posedge clk);
        periph_check.check_value("interrupt_request[2] pulses", 16'(periph_check.pulse_count[2]),
                                 16'd1);
        periph_check.end_test("uart frame");

        periph_check.set_active(reflet_pkg::src_timer);
        bus_write(0, 8'(reflet_pkg::src_timer));
        bus_write(3, 8'(reflet_pkg::src_timer));
        bus_write(1, 8'(reflet_pkg::src_none));
        bus_write(2, 8'(reflet_pkg::src_none));
        periph_check.clear_pulses();
        bus_write(11, 8'h01);
        wait_pulses(0, 3, 200, "routed timer interrupts");
        bus_write(11, 8'h00);
        periph_check.check_value("interrupt_request[3] pulses", 16'(periph_check.pulse_count[3]),
                                 16'd3);
        periph_check.check_value("interrupt_request[1] pulses", 16'(periph_check.pulse_count[1]),
                                 16'd0);
        periph_check.check_value("interrupt_request[2] pulses", 16'(periph_check.pulse_count[2]),
                                 16'd0);
        periph_check.end_test("routing");

        periph_check.final_report();
        if (periph_check.error_count == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== reflet_peripheral.f ====
source/reflet_pkg.sv
source/reflet_periph_bus_if.sv
source/reflet_periph_decoder.sv
source/reflet_interrupt_mux.sv
source/reflet_gpio.sv
source/reflet_timer.sv
source/reflet_uart_tx.sv
source/reflet_peripheral.sv
test/reflet_periph_checker.sv
test/tb_reflet_peripheral.sv
